// ==== hw/llr_mem_pkg.sv ====
package llr_mem_pkg;

  ////////////////////
  // sizes
  ////////////////////
  localparam int LLR_W        = 6;   // llr width, two's complement
  localparam int LLR_MAX      = 31;  // clip magnitude for channel llrs
  localparam int P            = 4;   // rows per cycle
  localparam int NB           = 6;   // circulant blocks per layer
  localparam int KB           = 4;   // systematic blocks, first KB banks
  localparam int WT           = 2;   // circulant weight
  localparam int SYM_PER_BANK = P * WT;   // symbols in one bank word
  localparam int SYM_PER_ROW  = NB * WT;  // symbols one row unit sees
  localparam int DEPTH        = 8;   // words per store
  localparam int ADDR_W       = 3;
  localparam int RD_LAT       = 3;   // read request to o_resp

  ////////////////////
  // vector types
  ////////////////////
  typedef logic signed [LLR_W-1:0]         llr_t;
  typedef logic [ADDR_W-1:0]               addr_t;
  typedef logic [SYM_PER_BANK*LLR_W-1:0]   bank_word_t;  // row j, weight k
  typedef logic [P*SYM_PER_ROW*LLR_W-1:0]  row_bus_t;    // row j, block i, weight k
  typedef logic [KB*SYM_PER_BANK-1:0]      hd_t;         // 1 = negative llr

  ////////////////////
  // request / response bundles
  ////////////////////
  typedef struct packed {
    logic     en;
    logic     layer;   // store picked by the layer that produced the data
    addr_t    addr;
    row_bus_t data;
  } wr_req_t;

  typedef struct packed {
    logic     en;
    addr_t    addr;
    row_bus_t data;    // raw channel llrs, clipped on the way in
  } load_req_t;

  typedef struct packed {
    logic  en;
    logic  layer;      // layer that will consume the data
    logic  unload;     // also return hard decisions
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic       en0;   // layer-0 result store
    logic       en1;   // layer-1 result store, also the load target
    addr_t      addr;
    bank_word_t data;
  } bank_wr_t;

  typedef struct packed {
    logic     valid;
    logic     hd_valid;
    row_bus_t data;
    hd_t      hd;
  } rd_resp_t;

endpackage

// ==== hw/llr_scatter.sv ====
`timescale 1ns/1ps

module llr_scatter (
  input  logic                   clk,
  input  logic                   rst,
  input  llr_mem_pkg::wr_req_t   i_wr,
  input  llr_mem_pkg::load_req_t i_load,
  input  llr_mem_pkg::rd_req_t   i_rd,
  output llr_mem_pkg::bank_wr_t  o_bank_wr [llr_mem_pkg::NB],
  output llr_mem_pkg::addr_t     o_rd_addr,
  output logic                   o_rd_en
);
  import llr_mem_pkg::*;

  row_bus_t sat_bus;   // load data after clipping
  row_bus_t src_bus;   // whichever source writes this cycle
  addr_t    wr_addr;
  logic     wr_l0;     // hits the layer-0 store
  logic     wr_l1;     // hits the layer-1 store

  // clip to +-LLR_MAX, so -32 comes out as -31
  function automatic llr_t sat_llr(input llr_t x);
    llr_t y;
    y = x;
    if (x < -LLR_MAX) begin
      y = llr_t'(-LLR_MAX);
    end else if (x > LLR_MAX) begin
      y = llr_t'(LLR_MAX);
    end
    return y;
  endfunction

  ////////////////////
  // write side
  ////////////////////
  always_comb begin
    for (int n = 0; n < P*SYM_PER_ROW; n++) begin
      sat_bus[n*LLR_W +: LLR_W] = sat_llr(i_load.data[n*LLR_W +: LLR_W]);
    end
  end

  assign src_bus = i_load.en ? sat_bus : i_wr.data;   // load and write never overlap
  assign wr_addr = i_load.en ? i_load.addr : i_wr.addr;

  // store decode, nothing lands while held in reset
  assign wr_l0 = i_wr.en & ~i_wr.layer & ~rst;
  assign wr_l1 = ((i_wr.en & i_wr.layer) | i_load.en) & ~rst;

  // row order -> per circulant word
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      o_bank_wr[i].en0  = wr_l0;
      o_bank_wr[i].en1  = wr_l1;
      o_bank_wr[i].addr = wr_addr;
      o_bank_wr[i].data = '0;
      for (int j = 0; j < P; j++) begin
        for (int k = 0; k < WT; k++) begin
          o_bank_wr[i].data[(j*WT + k)*LLR_W +: LLR_W] =
            src_bus[((j*NB + i)*WT + k)*LLR_W +: LLR_W];
        end
      end
    end
  end

  ////////////////////
  // read side
  ////////////////////
  assign o_rd_addr = i_rd.addr;  // unload shares the read address
  assign o_rd_en   = i_rd.en;

endmodule

// ==== hw/llr_circ_bank.sv ====
`timescale 1ns/1ps

module llr_circ_bank #(
  parameter int ROT = 0   // layer-1 read pattern, symbols
) (
  input  logic                    clk,
  input  logic                    rst,
  input  llr_mem_pkg::bank_wr_t   i_wr,
  input  llr_mem_pkg::addr_t      i_rd_addr,
  input  logic                    i_rd_en,
  output llr_mem_pkg::bank_word_t o_q0,
  output llr_mem_pkg::bank_word_t o_q1
);
  import llr_mem_pkg::*;

  bank_word_t mem0 [DEPTH];   // layer-0 results, read back in layer-1 pattern
  bank_word_t mem1 [DEPTH];   // layer-1 results and channel loads
  bank_word_t rd0;            // stage 1
  bank_word_t rd1;
  bank_word_t rot0;           // rd0 rotated, comb
  logic       rd_vld;         // stage 1 holds a fresh read

  ////////////////////
  // store writes
  ////////////////////
  always_ff @(posedge clk) begin
    if (i_wr.en0) begin
      mem0[i_wr.addr] <= i_wr.data;
    end
    if (i_wr.en1) begin
      mem1[i_wr.addr] <= i_wr.data;   // write or load, scatter already muxed
    end
  end

  ////////////////////
  // stage 1, registered read of both stores
  ////////////////////
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      rd0 <= mem0[i_rd_addr];  // old data on same-cycle write
      rd1 <= mem1[i_rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= i_rd_en;
    end
  end

  // out symbol s <- in symbol (s + ROT) mod 8
  always_comb begin
    for (int s = 0; s < SYM_PER_BANK; s++) begin
      rot0[s*LLR_W +: LLR_W] = rd0[((s + ROT) % SYM_PER_BANK)*LLR_W +: LLR_W];
    end
  end

  ////////////////////
  // stage 2
  ////////////////////
  // layer-0 path rotated, layer-1 path only delayed to match
  always_ff @(posedge clk) begin
    if (rd_vld) begin
      o_q0 <= rot0;
      o_q1 <= rd1;
    end
  end

endmodule

// ==== hw/llr_gather.sv ====
`timescale 1ns/1ps

module llr_gather (
  input  logic                    clk,
  input  logic                    rst,
  input  llr_mem_pkg::bank_word_t i_q0 [llr_mem_pkg::NB],
  input  llr_mem_pkg::bank_word_t i_q1 [llr_mem_pkg::NB],
  input  llr_mem_pkg::rd_req_t    i_rd,
  output llr_mem_pkg::rd_resp_t   o_resp
);
  import llr_mem_pkg::*;

  logic [1:0] en_pipe;       // [1] lines up with the bank outputs
  logic [1:0] layer_pipe;
  logic [1:0] unload_pipe;   // en and unload together
  bank_word_t sel [NB];      // layer mux result per bank
  row_bus_t   row_data;
  hd_t        hd_bits;

  ////////////////////
  // request flags, two stages like the banks
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      en_pipe     <= '0;
      layer_pipe  <= '0;
      unload_pipe <= '0;
    end else begin
      en_pipe     <= {en_pipe[0], i_rd.en};
      layer_pipe  <= {layer_pipe[0], i_rd.layer};
      unload_pipe <= {unload_pipe[0], i_rd.en & i_rd.unload};
    end
  end

  // layer 1 consumes the layer-0 store and vice versa
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      sel[i] = layer_pipe[1] ? i_q0[i] : i_q1[i];
    end
  end

  // per circulant word -> row order
  always_comb begin
    row_data = '0;
    for (int j = 0; j < P; j++) begin
      for (int i = 0; i < NB; i++) begin
        for (int k = 0; k < WT; k++) begin
          row_data[((j*NB + i)*WT + k)*LLR_W +: LLR_W] = sel[i][(j*WT + k)*LLR_W +: LLR_W];
        end
      end
    end
  end

  // hard decisions, msb of each layer-1 llr, systematic banks only
  always_comb begin
    for (int b = 0; b < KB; b++) begin
      for (int s = 0; s < SYM_PER_BANK; s++) begin
        hd_bits[b*SYM_PER_BANK + s] = i_q1[b][s*LLR_W + LLR_W - 1];
      end
    end
  end

  ////////////////////
  // output register
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      o_resp <= '0;
    end else begin
      o_resp.valid    <= en_pipe[1];
      o_resp.hd_valid <= unload_pipe[1];
      if (en_pipe[1]) begin
        o_resp.data <= row_data;   // held between reads
      end
      if (unload_pipe[1]) begin
        o_resp.hd <= hd_bits;
      end
    end
  end

endmodule

// ==== hw/llr_mem_top.sv ====
`timescale 1ns/1ps

module llr_mem_top (
  input  logic                   clk,
  input  logic                   rst,
  input  llr_mem_pkg::wr_req_t   i_wr,
  input  llr_mem_pkg::load_req_t i_load,
  input  llr_mem_pkg::rd_req_t   i_rd,
  output llr_mem_pkg::rd_resp_t  o_resp
);
  import llr_mem_pkg::*;

  bank_wr_t   bank_wr [NB];   // scatter -> banks
  addr_t      rd_addr;        // shared by all banks
  logic       rd_en;
  bank_word_t q0 [NB];        // layer-0 store, rotated
  bank_word_t q1 [NB];        // layer-1 store

  ////////////////////
  // row order in
  ////////////////////
  llr_scatter u_scatter (
    .clk       (clk),
    .rst       (rst),
    .i_wr      (i_wr),
    .i_load    (i_load),
    .i_rd      (i_rd),
    .o_bank_wr (bank_wr),
    .o_rd_addr (rd_addr),
    .o_rd_en   (rd_en)
  );

  // one bank per circulant, rotation = block index
  for (genvar b = 0; b < NB; b++) begin : g_bank
    llr_circ_bank #(
      .ROT (b)
    ) u_bank (
      .clk       (clk),
      .rst       (rst),
      .i_wr      (bank_wr[b]),
      .i_rd_addr (rd_addr),
      .i_rd_en   (rd_en),
      .o_q0      (q0[b]),
      .o_q1      (q1[b])
    );
  end

  ////////////////////
  // row order out
  ////////////////////
  llr_gather u_gather (
    .clk    (clk),
    .rst    (rst),
    .i_q0   (q0),
    .i_q1   (q1),
    .i_rd   (i_rd),
    .o_resp (o_resp)
  );

endmodule

// ==== tb/llr_mem_properties.sv ====
`timescale 1ns/1ps

module llr_mem_properties (
  input logic                   clk,
  input logic                   rst,
  input llr_mem_pkg::wr_req_t   i_wr,
  input llr_mem_pkg::load_req_t i_load,
  input llr_mem_pkg::rd_req_t   i_rd,
  input llr_mem_pkg::rd_resp_t  o_resp
);
  int unsigned fail_cnt = 0;   // failed assertions so far
  logic        rd_hd;          // read that also unloads
  logic        quiet;          // nothing valid on the output

  assign rd_hd = i_rd.en & i_rd.unload;
  assign quiet = ~o_resp.valid & ~o_resp.hd_valid;

  ////////////////////
  // read latency
  ////////////////////
  a_valid_lat: assert property (@(posedge clk) disable iff (rst) i_rd.en |-> ##3 o_resp.valid)
    else begin
      fail_cnt++;
      $error("valid did not follow a read request by 3 cycles");
    end
  a_valid_src: assert property (@(posedge clk) disable iff (rst)
                                o_resp.valid |-> $past(i_rd.en, 3))
    else begin
      fail_cnt++;
      $error("valid without a read request 3 cycles earlier");
    end
  a_hd_lat: assert property (@(posedge clk) disable iff (rst) rd_hd |-> ##3 o_resp.hd_valid)
    else begin
      fail_cnt++;
      $error("hd_valid did not follow an unload request by 3 cycles");
    end
  a_hd_src: assert property (@(posedge clk) disable iff (rst)
                             o_resp.hd_valid |-> $past(rd_hd, 3))
    else begin
      fail_cnt++;
      $error("hd_valid without an unload request 3 cycles earlier");
    end

  ////////////////////
  // reset and inputs
  ////////////////////
  a_rst_quiet: assert property (@(posedge clk) rst |=> quiet)   // also covers the cycle after
    else begin
      fail_cnt++;
      $error("output valid during reset");
    end
  a_wr_load: assert property (@(posedge clk) !(i_wr.en && i_load.en))
    else begin
      fail_cnt++;
      $error("write and load requested in the same cycle");
    end

endmodule

// ==== tb/llr_mem_tb.sv ====
`timescale 1ns/1ps

module llr_mem_tb;
  import llr_mem_pkg::*;

  logic      clk;
  logic      rst;
  wr_req_t   wr;
  load_req_t load;
  rd_req_t   rd;
  rd_resp_t  resp;
  row_bus_t  st0 [DEPTH];   // layer-0 store, kept in row order
  row_bus_t  st1 [DEPTH];   // layer-1 store, loads land here too
  rd_resp_t  exp_q [$];     // one entry per cycle, RD_LAT deep
  rd_resp_t  last_exp;      // data and hd hold between reads
  row_bus_t  ld;
  int        pending;       // requests still waiting for valid
  int        err_cnt = 0;
  int        to_cnt = 0;
  int        prop_cnt;

  llr_mem_top dut0 (
    .clk    (clk),
    .rst    (rst),
    .i_wr   (wr),
    .i_load (load),
    .i_rd   (rd),
    .o_resp (resp)
  );

  bind llr_mem_top llr_mem_properties u_props (
    .clk    (clk),
    .rst    (rst),
    .i_wr   (i_wr),
    .i_load (i_load),
    .i_rd   (i_rd),
    .o_resp (o_resp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // reference model
  ////////////////////
  function automatic llr_t clip_llr(input llr_t x);
    return (int'(x) < -LLR_MAX) ? llr_t'(-LLR_MAX) :
           (int'(x) > LLR_MAX) ? llr_t'(LLR_MAX) : x;
  endfunction

  // symbol index on the row bus of bank word symbol s in block b
  function automatic int bus_pos(input int b, input int s);
    return ((s / WT) * NB + b) * WT + s % WT;
  endfunction

  function automatic row_bus_t clip_bus(input row_bus_t d);
    row_bus_t r;
    for (int n = 0; n < P * SYM_PER_ROW; n++) begin
      r[n*LLR_W +: LLR_W] = clip_llr(d[n*LLR_W +: LLR_W]);
    end
    return r;
  endfunction

  // layer-1 view, block b rotated left by b symbols
  function automatic row_bus_t rotate_blocks(input row_bus_t d);
    row_bus_t r;
    for (int b = 0; b < NB; b++) begin
      for (int s = 0; s < SYM_PER_BANK; s++) begin
        r[bus_pos(b, s)*LLR_W +: LLR_W] = d[bus_pos(b, (s + b) % SYM_PER_BANK)*LLR_W +: LLR_W];
      end
    end
    return r;
  endfunction

  function automatic hd_t sign_bits(input row_bus_t d);
    hd_t h;
    for (int b = 0; b < KB; b++) begin   // systematic blocks only
      for (int s = 0; s < SYM_PER_BANK; s++) begin
        h[b*SYM_PER_BANK + s] = d[bus_pos(b, s)*LLR_W + LLR_W - 1];
      end
    end
    return h;
  endfunction

  function automatic row_bus_t rand_bus();
    row_bus_t r;
    for (int n = 0; n < $bits(row_bus_t) / 32; n++) begin
      r[n*32 +: 32] = $urandom;
    end
    return r;
  endfunction

  task automatic check_val(input string name, input row_bus_t got, input row_bus_t exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("Fail %0t ns %s got %0h exp %0h", $time, name, got, exp);
    end
  endtask

  // outputs read before this edge's updates land, inputs settled since +5 ns
  always @(posedge clk) begin
    rd_resp_t e;
    if (rst) begin
      exp_q.delete();
      repeat (RD_LAT) exp_q.push_back(rd_resp_t'(0));   // reset output, then empty pipe
      last_exp = '0;
      pending  = 0;
    end else begin
      e = exp_q.pop_front();
      check_val("o_resp.valid", row_bus_t'(resp.valid), row_bus_t'(e.valid));
      check_val("o_resp.hd_valid", row_bus_t'(resp.hd_valid), row_bus_t'(e.hd_valid));
      check_val("o_resp.data", resp.data, e.data);
      check_val("o_resp.hd", row_bus_t'(resp.hd), row_bus_t'(e.hd));
      if (resp.valid) pending--;
      e          = last_exp;
      e.valid    = 1'b0;
      e.hd_valid = 1'b0;
      if (rd.en) begin
        e.valid = 1'b1;
        e.data  = rd.layer ? rotate_blocks(st0[rd.addr]) : st1[rd.addr];
        if (rd.unload) begin
          e.hd_valid = 1'b1;
          e.hd       = sign_bits(st1[rd.addr]);
        end
        pending++;
      end
      exp_q.push_back(e);
      last_exp = e;
      // stores change after the read, same-cycle read sees old data
      if (wr.en && !wr.layer) st0[wr.addr] = wr.data;
      if (wr.en && wr.layer) st1[wr.addr] = wr.data;
      if (load.en) st1[load.addr] = clip_bus(load.data);
    end
  end

  ////////////////////
  // stimulus
  ////////////////////
  task automatic step();
    @(posedge clk);
    #5;
  endtask

  task automatic write_store(input logic layer, input addr_t a, input row_bus_t d);
    wr = '{en: 1'b1, layer: layer, addr: a, data: d};
    step();
    wr.en = 1'b0;
  endtask

  task automatic load_channel(input addr_t a, input row_bus_t d);
    load = '{en: 1'b1, addr: a, data: d};
    step();
    load.en = 1'b0;
  endtask

  task automatic issue_read(input logic layer, input logic unload, input addr_t a);
    rd = '{en: 1'b1, layer: layer, unload: unload, addr: a};
    step();
    rd = '0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (pending > 0 && n < 10) begin
      step();
      n++;
    end
    if (pending > 0) begin
      to_cnt++;
      $display("Timeout: read responses did not come back within 10 cycles");
    end
  endtask

  initial begin
    void'($urandom(32'ha6b7_4218));
    rst  = 1'b1;
    wr   = '0;
    load = '0;
    rd   = '0;
    repeat (2) @(posedge clk);
    #5;
    rst = 1'b0;
    repeat (3) step();   // zero outputs before any request
    // layer-1 store, read back for layer 0 as written
    for (int a = 0; a < DEPTH; a++) write_store(1'b1, addr_t'(a), rand_bus());
    for (int a = 0; a < DEPTH; a++) issue_read(1'b0, 1'b0, addr_t'(a));
    drain();
    // layer-0 store, rotated on the way out
    for (int a = 0; a < DEPTH; a++) write_store(1'b0, addr_t'(a), rand_bus());
    for (int a = 0; a < DEPTH; a++) begin
      issue_read(1'b1, 1'b0, addr_t'(a));
      issue_read(1'b0, 1'b0, addr_t'(a));   // layer-1 store untouched
    end
    drain();
    // channel loads with the edge values
    for (int a = 0; a < DEPTH; a++) begin
      ld = rand_bus();
      ld[0 +: LLR_W]       = llr_t'(-32);
      ld[LLR_W +: LLR_W]   = llr_t'(31);
      ld[2*LLR_W +: LLR_W] = llr_t'(-31);
      load_channel(addr_t'(a), ld);
    end
    for (int a = 0; a < DEPTH; a++) issue_read(1'b0, 1'b0, addr_t'(a));
    drain();
    // unload mixed with plain reads
    for (int a = 0; a < DEPTH; a++) begin
      issue_read(1'(a % 2), 1'b1, addr_t'(a));
      issue_read(1'b0, 1'b0, addr_t'(a));
    end
    drain();
    // back to back on alternating layers, then reads with gaps
    for (int n = 0; n < 12; n++) begin
      issue_read(1'(n % 2), (n % 3) == 0, addr_t'($urandom_range(0, 7)));
    end
    for (int n = 0; n < 6; n++) begin
      issue_read(1'(n % 2), 1'b0, addr_t'($urandom_range(0, 7)));
      step();
    end
    drain();
    repeat (4) step();
    prop_cnt = dut0.u_props.fail_cnt;
    $display("errors: data %0d, assertion %0d, timeout %0d", err_cnt, prop_cnt, to_cnt);
    if (err_cnt == 0 && prop_cnt == 0 && to_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== llr_mem_top.f ====
hw/llr_mem_pkg.sv
hw/llr_scatter.sv
hw/llr_circ_bank.sv
hw/llr_gather.sv
hw/llr_mem_top.sv
tb/llr_mem_properties.sv
tb/llr_mem_tb.sv

// ==== Makefile ====
# Verilator build and run of the LLR memory testbench

VERILATOR ?= verilator
TOP       ?= llr_mem_tb
FLIST     ?= llr_mem_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
